/* dv/tb_memory_game.sv */
module tb_memory_game;

    import memory_game_pkg::*;

    localparam int DEB_LEN  = 4;
    localparam int H_ACTIVE = 64;
    localparam int H_FRONT  = 4;
    localparam int H_SYNC   = 8;
    localparam int H_TOTAL  = 80;
    localparam int V_ACTIVE = 48;
    localparam int V_FRONT  = 2;
    localparam int V_SYNC   = 3;
    localparam int V_TOTAL  = 56;
    localparam int TILE_W   = H_ACTIVE / 8;
    localparam int TILE_H   = V_ACTIVE / 8;
    localparam int FRAME    = H_TOTAL * V_TOTAL;

    // Reference key codes, card 0 to card 15
    localparam logic [7:0] KEY_CODES [16] = '{
        8'h16, 8'h1E, 8'h26, 8'h25, 8'h15, 8'h1D, 8'h24, 8'h2D,
        8'h1C, 8'h1B, 8'h23, 8'h2B, 8'h1A, 8'h22, 8'h21, 8'h2A
    };

    logic        clk;
    logic        rst;
    logic        start_i;
    logic        hint_i;
    logic        key_valid_i;
    logic [7:0]  key_code_i;
    rgb_t        rom_data_i;
    logic [16:0] rom_addr_o;
    rgb_t        rgb_o;
    logic        hsync_o;
    logic        vsync_o;
    game_state_t state_o;
    card_vec_t   matched_o;

    game_state_t exp_state;
    card_vec_t   exp_matched;
    logic        exp_flip9;
    logic        no_keys_yet;
    int          h_ref;
    int          v_ref;
    logic        act_ref;
    logic        hs_win;
    logic        vs_win;
    logic        act_q;
    logic        hs_q;
    logic        vs_q;
    logic [16:0] addr_q;
    logic [11:0] exp_pixel;
    logic        in_tile9;
    logic [16:0] exp_addr9;

    memory_game_top #(
        .DEBOUNCE_LEN(DEB_LEN),
        .H_ACTIVE    (H_ACTIVE),
        .H_FRONT     (H_FRONT),
        .H_SYNC      (H_SYNC),
        .H_TOTAL     (H_TOTAL),
        .V_ACTIVE    (V_ACTIVE),
        .V_FRONT     (V_FRONT),
        .V_SYNC      (V_SYNC),
        .V_TOTAL     (V_TOTAL)
    ) dut0 (
        .clk        (clk),
        .rst        (rst),
        .start_i    (start_i),
        .hint_i     (hint_i),
        .key_valid_i(key_valid_i),
        .key_code_i (key_code_i),
        .rom_data_i (rom_data_i),
        .rom_addr_o (rom_addr_o),
        .rgb_o      (rgb_o),
        .hsync_o    (hsync_o),
        .vsync_o    (vsync_o),
        .state_o    (state_o),
        .matched_o  (matched_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [11:0] pixel_for_addr(input logic [16:0] addr);
        return 12'(addr * 17'd211) ^ 12'(addr >> 4) ^ 12'h5A3;
    endfunction

    function automatic game_state_t next_game_state(input game_state_t s);
        case (s)
            IDLE:    return PREVIEW;
            PREVIEW: return PLAY;
            FINISH:  return IDLE;
            default: return s;
        endcase
    endfunction

    // Reference beam, sync windows and a ROM with one cycle of latency
    assign act_ref = (h_ref < H_ACTIVE) && (v_ref < V_ACTIVE);
    assign hs_win  = (h_ref >= H_ACTIVE + H_FRONT) && (h_ref < H_ACTIVE + H_FRONT + H_SYNC);
    assign vs_win  = (v_ref >= V_ACTIVE + V_FRONT) && (v_ref < V_ACTIVE + V_FRONT + V_SYNC);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_ref  <= 0;
            v_ref  <= 0;
            act_q  <= 1'b0;
            hs_q   <= 1'b0;
            vs_q   <= 1'b0;
            addr_q <= '0;
        end else begin
            if (h_ref == H_TOTAL - 1) begin
                h_ref <= 0;
                v_ref <= (v_ref == V_TOTAL - 1) ? 0 : v_ref + 1;
            end else begin
                h_ref <= h_ref + 1;
            end
            act_q  <= act_ref;
            hs_q   <= hs_win;
            vs_q   <= vs_win;
            addr_q <= rom_addr_o;
        end
    end

    assign rom_data_i = pixel_for_addr(addr_q);
    assign exp_pixel  = act_q ? pixel_for_addr(addr_q) : 12'h000;

    // Card 9 sits in tile row 2, column 1
    always_comb begin
        int hx;
        int vy;
        int row_in;
        hx     = h_ref / 2;
        vy     = v_ref / 2;
        row_in = vy % TILE_H;
        if (exp_flip9) begin
            row_in = TILE_H - 1 - row_in;
        end
        in_tile9  = act_ref && (hx / TILE_W == 1) && (vy / TILE_H == 2);
        exp_addr9 = 17'(row_in * TILE_W + hx % TILE_W);
    end

    task automatic stop_with_failure();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("Fail %s: got %h expected %h", name, got, expected);
        stop_with_failure();
    endtask

    task automatic abort_run(input string why);
        $display("Timeout: %s", why);
        stop_with_failure();
    endtask

    a_reset_outputs: assert property (
        @(posedge clk) (rst && $past(rst)) |-> (state_o == IDLE && matched_o == '0 && rgb_o == '0)
    ) else report_mismatch("state_o,matched_o,rgb_o",
                           {$sampled(state_o), $sampled(matched_o), $sampled(rgb_o)}, 0);

    a_idle_clears: assert property (
        @(posedge clk) disable iff (rst) (state_o == IDLE) |=> (matched_o == '0)
    ) else report_mismatch("matched_o", $sampled(matched_o), 0);

    a_start_step: assert property (
        @(posedge clk) disable iff (rst) $rose(start_i) |-> ##(DEB_LEN + 2) (state_o == exp_state)
    ) else report_mismatch("state_o", $sampled(state_o), $sampled(exp_state));

    a_finish: assert property (
        @(posedge clk) disable iff (rst)
        (state_o == PLAY && matched_o == '1) |=> (state_o == FINISH)
    ) else report_mismatch("state_o", $sampled(state_o), FINISH);

    // The pixel path lags visibility by one cycle
    a_hidden_dark: assert property (
        @(posedge clk) disable iff (rst)
        (state_o == PLAY && $past(state_o) == PLAY && no_keys_yet && !$past(hint_i))
        |-> (rgb_o == '0)
    ) else report_mismatch("rgb_o", $sampled(rgb_o), 0);

    a_hint_pixel: assert property (
        @(posedge clk) disable iff (rst) $past(hint_i) |-> (rgb_o == exp_pixel)
    ) else report_mismatch("rgb_o", $sampled(rgb_o), $sampled(exp_pixel));

    a_match: assert property (
        @(posedge clk) disable iff (rst) key_valid_i |=> (matched_o == exp_matched)
    ) else report_mismatch("matched_o", $sampled(matched_o), $sampled(exp_matched));

    a_mirror_addr: assert property (
        @(posedge clk) disable iff (rst)
        (state_o == PLAY && in_tile9) |-> (rom_addr_o == exp_addr9)
    ) else report_mismatch("rom_addr_o", $sampled(rom_addr_o), $sampled(exp_addr9));

    a_hsync: assert property (
        @(posedge clk) disable iff (rst) hsync_o == !hs_q
    ) else report_mismatch("hsync_o", $sampled(hsync_o), !$sampled(hs_q));

    a_vsync: assert property (
        @(posedge clk) disable iff (rst) vsync_o == !vs_q
    ) else report_mismatch("vsync_o", $sampled(vsync_o), !$sampled(vs_q));

    task automatic wait_state(input game_state_t target);
        int n;
        n = 0;
        while (state_o != target && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (state_o != target) begin
            abort_run("game state did not reach the expected value");
        end
    endtask

    task automatic wait_vsync_fall();
        int n;
        n = 0;
        while (!vsync_o && n < 2 * FRAME) begin
            @(negedge clk);
            n++;
        end
        while (vsync_o && n < 2 * FRAME) begin
            @(negedge clk);
            n++;
        end
        if (n >= 2 * FRAME) begin
            abort_run("vertical sync never started");
        end
    endtask

    task automatic press_start();
        @(negedge clk);
        exp_state = next_game_state(exp_state);
        start_i   = 1'b1;
        repeat (10) @(negedge clk);
        start_i = 1'b0;
        wait_state(exp_state);
    endtask

    task automatic press_key(input logic [7:0] code, input card_vec_t matched_after);
        @(negedge clk);
        no_keys_yet = 1'b0;
        exp_matched = matched_after;
        key_code_i  = code;
        key_valid_i = 1'b1;
        @(negedge clk);
        key_valid_i = 1'b0;
    endtask

    task automatic try_pair(input int a, input int b, input logic expect_match);
        card_vec_t after;
        after = exp_matched;
        press_key(KEY_CODES[a], after);
        if (expect_match) begin
            after[a] = 1'b1;
            after[b] = 1'b1;
        end
        press_key(KEY_CODES[b], after);
    endtask

    initial begin
        int k;
        rst         = 1'b1;
        start_i     = 1'b0;
        hint_i      = 1'b0;
        key_valid_i = 1'b0;
        key_code_i  = '0;
        exp_state   = IDLE;
        exp_matched = '0;
        exp_flip9   = 1'b0;
        no_keys_yet = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        // Third press lands in PLAY and must not move the state
        press_start();
        press_start();
        press_start();
        wait_vsync_fall();
        wait_vsync_fall();
        @(negedge clk);
        hint_i = 1'b1;
        wait_vsync_fall();
        @(negedge clk);
        hint_i = 1'b0;

        // Mirror card 8 so it matches card 0
        press_key(SC_SHIFT, exp_matched);
        press_key(KEY_CODES[8], exp_matched);
        try_pair(0, 8, 1'b1);
        try_pair(1, 9, 1'b0);
        press_key(SC_SHIFT, exp_matched);
        press_key(KEY_CODES[9], exp_matched);
        exp_flip9 = 1'b1;
        wait_vsync_fall();
        wait_vsync_fall();
        try_pair(1, 9, 1'b1);
        for (k = 2; k < 8; k++) begin
            try_pair(k, k + 8, 1'b1);
        end
        exp_state = FINISH;
        wait_state(FINISH);

        press_start();
        wait_vsync_fall();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* hw/button_pulse.sv */
module button_pulse #(
    parameter int DEBOUNCE_LEN = 7
) (
    input  logic clk,
    input  logic rst,
    input  logic start_i,
    output logic start_pulse_o
);

    logic [DEBOUNCE_LEN-1:0] shreg_q;
    logic                    pressed;
    logic                    pressed_q;
    logic                    pulse_q;

    // Button counts as pressed only after a full run of ones
    assign pressed = &shreg_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shreg_q   <= '0;
            pressed_q <= 1'b0;
            pulse_q   <= 1'b0;
        end else begin
            shreg_q   <= {shreg_q[DEBOUNCE_LEN-2:0], start_i};
            pressed_q <= pressed;
            pulse_q   <= pressed & ~pressed_q;
        end
    end

    assign start_pulse_o = pulse_q;

    a_single_cycle: assert property (
        @(posedge clk) disable iff (rst) start_pulse_o |=> !start_pulse_o
    ) else $error("start pulse lasted more than one cycle");

endmodule

/* hw/card_board.sv */
module card_board (
    input  logic                         clk,
    input  logic                         rst,
    input  memory_game_pkg::game_state_t state_i,
    input  logic                         start_pulse_i,
    input  logic                         key_valid_i,
    input  memory_game_pkg::scancode_t   key_code_i,
    input  logic                         hint_i,
    output memory_game_pkg::card_vec_t   visible_o,
    output memory_game_pkg::card_vec_t   flipped_o,
    output memory_game_pkg::card_vec_t   matched_o,
    output logic                         all_matched_o
);

    import memory_game_pkg::*;

    key_event_t ev;
    card_vec_t  shown_q;
    card_vec_t  flipped_q;
    card_vec_t  matched_q;
    logic       shift_q;
    logic       pend_valid_q;
    card_idx_t  pend_idx_q;
    logic [3:0] pair_cnt_q;
    logic       pair_ok;

    assign ev = decode_key(key_valid_i, key_code_i);

    // Second key against the pending card
    assign pair_ok = ((pend_idx_q ^ ev.idx) == card_idx_t'(NUM_PAIRS))
                  && (flipped_q[pend_idx_q] == flipped_q[ev.idx])
                  && !matched_q[pend_idx_q]
                  && !matched_q[ev.idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shown_q      <= '0;
            flipped_q    <= INIT_FLIPPED;
            matched_q    <= '0;
            shift_q      <= 1'b0;
            pend_valid_q <= 1'b0;
            pend_idx_q   <= '0;
            pair_cnt_q   <= '0;
        end else begin
            case (state_i)
                IDLE, PREVIEW: begin
                    flipped_q    <= INIT_FLIPPED;
                    matched_q    <= '0;
                    pair_cnt_q   <= '0;
                    shift_q      <= 1'b0;
                    pend_valid_q <= 1'b0;
                    // Preview shows the board until play begins
                    shown_q      <= (state_i == PREVIEW && !start_pulse_i) ? '1 : '0;
                end
                PLAY: begin
                    if (ev.valid && ev.is_shift) begin
                        shift_q <= 1'b1;
                    end else if (ev.valid && ev.is_enter) begin
                        shown_q <= shown_q & matched_q;
                    end else if (ev.valid && ev.is_card) begin
                        shown_q[ev.idx] <= 1'b1;
                        if (shift_q) begin
                            if (pend_valid_q) begin
                                flipped_q[pend_idx_q] <= ~flipped_q[pend_idx_q];
                            end else begin
                                flipped_q[ev.idx] <= ~flipped_q[ev.idx];
                            end
                            shift_q      <= 1'b0;
                            pend_valid_q <= 1'b0;
                        end else if (!pend_valid_q) begin
                            pend_valid_q <= 1'b1;
                            pend_idx_q   <= ev.idx;
                        end else begin
                            pend_valid_q <= 1'b0;
                            if (pair_ok) begin
                                matched_q[pend_idx_q] <= 1'b1;
                                matched_q[ev.idx]     <= 1'b1;
                                pair_cnt_q            <= pair_cnt_q + 4'd1;
                            end
                        end
                    end
                end
                FINISH: begin
                    shown_q <= '1;
                end
                default: shown_q <= '0;
            endcase
        end
    end

    assign visible_o     = shown_q | matched_q | {NUM_CARDS{hint_i}};
    assign flipped_o     = flipped_q;
    assign matched_o     = matched_q;
    assign all_matched_o = (pair_cnt_q == 4'(NUM_PAIRS));

    a_cnt_bound: assert property (
        @(posedge clk) disable iff (rst) pair_cnt_q <= 4'(NUM_PAIRS)
    ) else $error("pair count overflow %0h", pair_cnt_q);

endmodule

/* hw/frame_composer.sv */
module frame_composer #(
    parameter int H_ACTIVE = 640,
    parameter int V_ACTIVE = 480
) (
    input  logic                       clk,
    input  logic                       rst,
    input  memory_game_pkg::beam_t     beam_i,
    input  memory_game_pkg::sync_t     sync_i,
    input  memory_game_pkg::card_vec_t visible_i,
    input  memory_game_pkg::card_vec_t flipped_i,
    output logic [16:0]                rom_addr_o,
    input  memory_game_pkg::rgb_t      rom_data_i,
    output memory_game_pkg::rgb_t      rgb_o,
    output logic                       hsync_o,
    output logic                       vsync_o
);

    import memory_game_pkg::*;

    // Tiles on the half-resolution grid
    localparam int TILE_W = H_ACTIVE / 8;
    localparam int TILE_H = V_ACTIVE / 8;

    logic [9:0] x;
    logic [9:0] y;
    logic [1:0] col;
    logic [1:0] row;
    card_idx_t  tile;
    logic [9:0] in_col;
    logic [9:0] in_row;
    card_idx_t  tile_q;
    card_vec_t  vis_q;
    logic       active_q;
    sync_t      sync_q;

    assign x    = beam_i.h >> 1;
    assign y    = beam_i.v >> 1;
    assign col  = 2'(x / 10'(TILE_W));
    assign row  = 2'(y / 10'(TILE_H));
    assign tile = {row, col};

    // Flipped tiles read their rows bottom up
    assign in_col = x % 10'(TILE_W);
    assign in_row = flipped_i[tile] ? 10'(TILE_H - 1) - (y % 10'(TILE_H))
                                    : y % 10'(TILE_H);

    assign rom_addr_o = 17'(in_row) * 17'(TILE_W) + 17'(in_col);

    // Line up tile, visibility and sync with the ROM latency
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tile_q   <= '0;
            vis_q    <= '0;
            active_q <= 1'b0;
            sync_q   <= '1;
        end else begin
            tile_q   <= tile;
            vis_q    <= visible_i;
            active_q <= beam_i.active;
            sync_q   <= sync_i;
        end
    end

    assign rgb_o   = (active_q && vis_q[tile_q]) ? rom_data_i : '0;
    assign hsync_o = sync_q.hsync;
    assign vsync_o = sync_q.vsync;

endmodule

/* hw/game_fsm.sv */
module game_fsm (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start_pulse_i,
    input  logic                        all_matched_i,
    output memory_game_pkg::game_state_t state_o
);

    import memory_game_pkg::*;

    game_state_t state_q;
    game_state_t state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start_pulse_i) state_d = PREVIEW;
            end
            PREVIEW: begin
                if (start_pulse_i) state_d = PLAY;
            end
            PLAY: begin
                if (all_matched_i) state_d = FINISH;
            end
            FINISH: begin
                if (start_pulse_i) state_d = IDLE;
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign state_o = state_q;

    // Play only ends through a completed board
    a_play_exit: assert property (
        @(posedge clk) disable iff (rst) (state_q == PLAY) |=> (state_q inside {PLAY, FINISH})
    ) else $error("state left PLAY for %0d", state_q);

endmodule

/* hw/memory_game_pkg.sv */
package memory_game_pkg;

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        PREVIEW = 2'd1,
        PLAY    = 2'd2,
        FINISH  = 2'd3
    } game_state_t;

    localparam int NUM_CARDS = 16;
    localparam int NUM_PAIRS = 8;

    // Card k pairs with card k ^ 8
    typedef logic [3:0]           card_idx_t;
    typedef logic [NUM_CARDS-1:0] card_vec_t;
    typedef logic [7:0]           scancode_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    typedef struct packed {
        logic      valid;
        logic      is_card;
        logic      is_shift;
        logic      is_enter;
        card_idx_t idx;
    } key_event_t;

    typedef struct packed {
        logic [9:0] h;
        logic [9:0] v;
        logic       active;
    } beam_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
    } sync_t;

    localparam scancode_t SC_SHIFT = 8'h12;
    localparam scancode_t SC_ENTER = 8'h5A;

    // Keys 1 2 3 4 / Q W E R / A S D F / Z X C V
    localparam scancode_t CARD_CODES [NUM_CARDS] = '{
        8'h16, 8'h1E, 8'h26, 8'h25,
        8'h15, 8'h1D, 8'h24, 8'h2D,
        8'h1C, 8'h1B, 8'h23, 8'h2B,
        8'h1A, 8'h22, 8'h21, 8'h2A
    };

    // Cards 0, 1, 7 and 15 start mirrored
    localparam card_vec_t INIT_FLIPPED = 16'h8083;

    function automatic key_event_t decode_key(input logic strobe, input scancode_t code);
        key_event_t ev;
        ev          = '0;
        ev.valid    = strobe;
        ev.is_shift = (code == SC_SHIFT);
        ev.is_enter = (code == SC_ENTER);
        for (int i = 0; i < NUM_CARDS; i++) begin
            if (code == CARD_CODES[i]) begin
                ev.is_card = 1'b1;
                ev.idx     = card_idx_t'(i);
            end
        end
        return ev;
    endfunction

endpackage

/* hw/memory_game_top.sv */
module memory_game_top #(
    parameter int DEBOUNCE_LEN = 7,
    parameter int H_ACTIVE     = 640,
    parameter int H_FRONT      = 16,
    parameter int H_SYNC       = 96,
    parameter int H_TOTAL      = 800,
    parameter int V_ACTIVE     = 480,
    parameter int V_FRONT      = 10,
    parameter int V_SYNC       = 2,
    parameter int V_TOTAL      = 525
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start_i,
    input  logic                         hint_i,
    input  logic                         key_valid_i,
    input  memory_game_pkg::scancode_t   key_code_i,
    input  memory_game_pkg::rgb_t        rom_data_i,
    output logic [16:0]                  rom_addr_o,
    output memory_game_pkg::rgb_t        rgb_o,
    output logic                         hsync_o,
    output logic                         vsync_o,
    output memory_game_pkg::game_state_t state_o,
    output memory_game_pkg::card_vec_t   matched_o
);

    import memory_game_pkg::*;

    logic        start_pulse;
    logic        all_matched;
    game_state_t state;
    beam_t       beam;
    sync_t       sync;
    card_vec_t   visible;
    card_vec_t   flipped;

    button_pulse #(
        .DEBOUNCE_LEN(DEBOUNCE_LEN)
    ) u_button_pulse (
        .clk          (clk),
        .rst          (rst),
        .start_i      (start_i),
        .start_pulse_o(start_pulse)
    );

    game_fsm u_game_fsm (
        .clk          (clk),
        .rst          (rst),
        .start_pulse_i(start_pulse),
        .all_matched_i(all_matched),
        .state_o      (state)
    );

    vga_timing #(
        .H_ACTIVE(H_ACTIVE),
        .H_FRONT (H_FRONT),
        .H_SYNC  (H_SYNC),
        .H_TOTAL (H_TOTAL),
        .V_ACTIVE(V_ACTIVE),
        .V_FRONT (V_FRONT),
        .V_SYNC  (V_SYNC),
        .V_TOTAL (V_TOTAL)
    ) u_vga_timing (
        .clk   (clk),
        .rst   (rst),
        .beam_o(beam),
        .sync_o(sync)
    );

    card_board u_card_board (
        .clk          (clk),
        .rst          (rst),
        .state_i      (state),
        .start_pulse_i(start_pulse),
        .key_valid_i  (key_valid_i),
        .key_code_i   (key_code_i),
        .hint_i       (hint_i),
        .visible_o    (visible),
        .flipped_o    (flipped),
        .matched_o    (matched_o),
        .all_matched_o(all_matched)
    );

    frame_composer #(
        .H_ACTIVE(H_ACTIVE),
        .V_ACTIVE(V_ACTIVE)
    ) u_frame_composer (
        .clk       (clk),
        .rst       (rst),
        .beam_i    (beam),
        .sync_i    (sync),
        .visible_i (visible),
        .flipped_i (flipped),
        .rom_addr_o(rom_addr_o),
        .rom_data_i(rom_data_i),
        .rgb_o     (rgb_o),
        .hsync_o   (hsync_o),
        .vsync_o   (vsync_o)
    );

    assign state_o = state;

endmodule

/* hw/vga_timing.sv */
module vga_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_TOTAL  = 800,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_TOTAL  = 525
) (
    input  logic                   clk,
    input  logic                   rst,
    output memory_game_pkg::beam_t beam_o,
    output memory_game_pkg::sync_t sync_o
);

    import memory_game_pkg::*;

    localparam int HS_START = H_ACTIVE + H_FRONT;
    localparam int HS_END   = HS_START + H_SYNC;
    localparam int VS_START = V_ACTIVE + V_FRONT;
    localparam int VS_END   = VS_START + V_SYNC;

    logic [9:0] h_cnt_q;
    logic [9:0] v_cnt_q;
    logic       h_in;
    logic       v_in;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_cnt_q <= '0;
            v_cnt_q <= '0;
        end else if (h_cnt_q == 10'(H_TOTAL - 1)) begin
            h_cnt_q <= '0;
            // Line steps on pixel wrap
            if (v_cnt_q == 10'(V_TOTAL - 1)) begin
                v_cnt_q <= '0;
            end else begin
                v_cnt_q <= v_cnt_q + 10'd1;
            end
        end else begin
            h_cnt_q <= h_cnt_q + 10'd1;
        end
    end

    assign h_in = (h_cnt_q < 10'(H_ACTIVE));
    assign v_in = (v_cnt_q < 10'(V_ACTIVE));

    always_comb begin
        beam_o.h      = h_in ? h_cnt_q : 10'd0;
        beam_o.v      = v_in ? v_cnt_q : 10'd0;
        beam_o.active = h_in & v_in;
        // Syncs are active low
        sync_o.hsync  = !((h_cnt_q >= 10'(HS_START)) && (h_cnt_q < 10'(HS_END)));
        sync_o.vsync  = !((v_cnt_q >= 10'(VS_START)) && (v_cnt_q < 10'(VS_END)));
    end

    a_cnt_range: assert property (
        @(posedge clk) disable iff (rst)
        (h_cnt_q < 10'(H_TOTAL)) && (v_cnt_q < 10'(V_TOTAL))
    ) else $error("beam counters out of range h=%0h v=%0h", h_cnt_q, v_cnt_q);

endmodule

/* src.f */
hw/memory_game_pkg.sv
hw/button_pulse.sv
hw/game_fsm.sv
hw/vga_timing.sv
hw/card_board.sv
hw/frame_composer.sv
hw/memory_game_top.sv
dv/tb_memory_game.sv
